// File: Bender.yml
package:
  name: sram_axi

sources:
  - include_dirs:
      - design
    files:
      - design/sram_axi_pkg.sv
      - design/sram_axi_if.sv
      - design/sram_mem_if.sv
      - design/sram_axi_master.sv
      - design/sram_axi_slave.sv
      - design/sram_mem.sv
      - design/sram_axi_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/sram_axi_tb.sv

// File: design/sram_axi_defines.svh
// ####################################################################
// Global sizes and start values for the AXI4 SRAM subsystem
// SRAM_STRB_W must stay at SRAM_DATA_W / 8 for the byte strobes
// ####################################################################

`ifndef SRAM_AXI_DEFINES_SVH
`define SRAM_AXI_DEFINES_SVH

`define SRAM_ADDR_W     8     // Word address width
`define SRAM_DATA_W     64    // Data bus and word width
`define SRAM_STRB_W     8     // One strobe per data byte
`define SRAM_DEPTH      256   // Number of SRAM words

// Traffic generator start values
`define SRAM_ADDR_INIT  1
`define SRAM_WDATA_INIT 20

`endif

// File: design/sram_axi_if.sv
// ####################################################################
// Single-beat AXI4 subset without IDs, lengths or error responses
// ####################################################################

`include "sram_axi_defines.svh"

interface sram_axi_if;

    logic [`SRAM_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;

    logic [`SRAM_DATA_W-1:0] wdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;

    logic                    bvalid;
    logic                    bready;

    logic [`SRAM_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;

    logic [`SRAM_DATA_W-1:0] rdata;
    logic                    rlast;
    logic                    rvalid;
    logic                    rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wlast, wvalid, bready,
        output araddr, arvalid, rready,
        input  awready, wready, bvalid, arready, rdata, rlast, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wlast, wvalid, bready,
        input  araddr, arvalid, rready,
        output awready, wready, bvalid, arready, rdata, rlast, rvalid
    );

endinterface

// File: design/sram_axi_master.sv
// ####################################################################
// Traffic master that writes while i_rw_type is high and reads while low
// The level is sampled only when a channel is idle
// ####################################################################

`include "sram_axi_defines.svh"

module sram_axi_master
    import sram_axi_pkg::*;
(
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_rw_type,
    sram_axi_if.master              m_axi,
    output logic                    o_rvalid,
    output logic [`SRAM_DATA_W-1:0] o_rdata,
    output logic [`SRAM_ADDR_W-1:0] o_rd_addr,
    output logic                    o_wr_done
);

    rw_op_e                  w_op;
    mst_state_e              r_wr_state;
    mst_state_e              r_rd_state;
    logic [`SRAM_ADDR_W-1:0] r_wr_addr;
    logic [`SRAM_ADDR_W-1:0] r_rd_addr;
    logic [`SRAM_DATA_W-1:0] r_wdata;
    logic                    r_awvalid;
    logic                    r_wvalid;
    logic                    r_arvalid;
    logic                    w_rd_fire;

    assign w_op = i_rw_type ? op_write : op_read;

    assign m_axi.awaddr  = r_wr_addr;
    assign m_axi.awvalid = r_awvalid;
    assign m_axi.wdata   = r_wdata;
    assign m_axi.wstrb   = '1;      // Full word writes only
    assign m_axi.wlast   = 1'b1;    // Every burst is a single beat
    assign m_axi.wvalid  = r_wvalid;
    assign m_axi.bready  = 1'b1;
    assign m_axi.araddr  = r_rd_addr;
    assign m_axi.arvalid = r_arvalid;
    assign m_axi.rready  = 1'b1;

    // Last read beat accepted while waiting for the response
    assign w_rd_fire = (r_rd_state == ms_resp) && m_axi.rvalid && m_axi.rready && m_axi.rlast;

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_wr_state <= ms_idle;
            r_wr_addr  <= `SRAM_ADDR_W'(`SRAM_ADDR_INIT);
            r_wdata    <= `SRAM_DATA_W'(`SRAM_WDATA_INIT);
            r_awvalid  <= 1'b0;
            r_wvalid   <= 1'b0;
            o_wr_done  <= 1'b0;
        end else begin
            o_wr_done <= 1'b0;
            case (r_wr_state)
                ms_idle: if (w_op == op_write) begin
                    r_awvalid  <= 1'b1;
                    r_wr_state <= ms_addr;
                end
                ms_addr: if (m_axi.awready) begin    // awvalid is high in this state
                    r_awvalid  <= 1'b0;
                    r_wvalid   <= 1'b1;
                    r_wr_state <= ms_data;
                end
                ms_data: if (m_axi.wready) begin
                    r_wvalid   <= 1'b0;
                    r_wr_state <= ms_resp;
                end
                ms_resp: if (m_axi.bvalid && m_axi.bready) begin
                    o_wr_done  <= 1'b1;
                    r_wr_addr  <= r_wr_addr + `SRAM_ADDR_W'(1);
                    r_wdata    <= r_wdata + `SRAM_DATA_W'(1);
                    r_wr_state <= ms_idle;
                end
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_rd_state <= ms_idle;
            r_rd_addr  <= `SRAM_ADDR_W'(`SRAM_ADDR_INIT);
            r_arvalid  <= 1'b0;
            o_rvalid   <= 1'b0;
        end else begin
            o_rvalid <= w_rd_fire;
            case (r_rd_state)
                ms_idle: if (w_op == op_read) begin
                    r_arvalid  <= 1'b1;
                    r_rd_state <= ms_addr;
                end
                ms_addr: if (m_axi.arready) begin
                    r_arvalid  <= 1'b0;
                    r_rd_state <= ms_resp;
                end
                ms_resp: if (w_rd_fire) begin
                    r_rd_addr  <= r_rd_addr + `SRAM_ADDR_W'(1);
                    r_rd_state <= ms_idle;
                end
                default: r_rd_state <= ms_idle;    // ms_data has no read meaning
            endcase
        end
    end

    // Read result keeps the address it was requested at
    always_ff @(posedge i_aclk) begin
        if (w_rd_fire) begin
            o_rdata   <= m_axi.rdata;
            o_rd_addr <= r_rd_addr;
        end
    end

endmodule

// File: design/sram_axi_pkg.sv
// ####################################################################
// Shared enums for the traffic master and the AXI4 slave
// ####################################################################

package sram_axi_pkg;

    // Direction requested by the i_rw_type level
    typedef enum logic {
        op_read,
        op_write
    } rw_op_e;

    // One state word per master channel, the read side skips ms_data
    typedef enum logic [1:0] {
        ms_idle,
        ms_addr,
        ms_data,
        ms_resp
    } mst_state_e;

    typedef enum logic [1:0] {
        ss_idle,
        ss_wdata,
        ss_bresp,
        ss_rdata
    } slv_state_e;

endpackage

// File: design/sram_axi_slave.sv
// ####################################################################
// Single-beat AXI4 slave in front of the SRAM, write wins over read
// Responses are always OKAY and one transaction is served at a time
// ####################################################################

`include "sram_axi_defines.svh"

module sram_axi_slave
    import sram_axi_pkg::*;
(
    input  logic       i_aclk,
    input  logic       i_areset_n,
    sram_axi_if.slave  s_axi,
    sram_mem_if.ctrl   mem
);

    slv_state_e              r_state;
    logic [`SRAM_ADDR_W-1:0] r_addr;
    logic                    w_aw_fire;
    logic                    w_w_fire;
    logic                    w_ar_fire;

    // Readies only open in the states that can take the beat
    assign s_axi.awready = (r_state == ss_idle);
    assign s_axi.arready = (r_state == ss_idle) && !s_axi.awvalid;
    assign s_axi.wready  = (r_state == ss_wdata);

    // Responses are state driven so they hold until accepted
    assign s_axi.bvalid  = (r_state == ss_bresp);
    assign s_axi.rvalid  = (r_state == ss_rdata);
    assign s_axi.rlast   = (r_state == ss_rdata);
    assign s_axi.rdata   = mem.rdata;    // SRAM output is stable until the next read

    assign w_aw_fire = s_axi.awvalid && s_axi.awready;
    assign w_w_fire  = s_axi.wvalid && s_axi.wready;
    assign w_ar_fire = s_axi.arvalid && s_axi.arready;

    // Read is issued on the AR handshake so data is ready a cycle later
    assign mem.en    = w_w_fire || w_ar_fire;
    assign mem.we    = w_w_fire;
    assign mem.addr  = w_w_fire ? r_addr : s_axi.araddr;
    assign mem.wdata = s_axi.wdata;
    assign mem.wstrb = s_axi.wstrb;

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state <= ss_idle;
        end else begin
            case (r_state)
                ss_idle: begin
                    if (w_aw_fire) begin
                        r_state <= ss_wdata;
                    end else if (w_ar_fire) begin
                        r_state <= ss_rdata;
                    end
                end
                ss_wdata: if (w_w_fire && s_axi.wlast) begin
                    r_state <= ss_bresp;
                end
                ss_bresp: if (s_axi.bready) begin
                    r_state <= ss_idle;
                end
                ss_rdata: if (s_axi.rready) begin
                    r_state <= ss_idle;
                end
            endcase
        end
    end

    // Write address is needed until the W beat arrives
    always_ff @(posedge i_aclk) begin
        if (w_aw_fire) begin
            r_addr <= s_axi.awaddr;
        end
    end

endmodule

// File: design/sram_axi_top.sv
// ####################################################################
// Traffic master, AXI4 slave and SRAM joined into one block
// o_rdata and o_rd_addr are valid only while o_rvalid is high
// ####################################################################

`include "sram_axi_defines.svh"

module sram_axi_top (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    input  logic                    i_rw_type,     // High for writes, low for reads
    output logic                    o_rvalid,
    output logic [`SRAM_DATA_W-1:0] o_rdata,
    output logic [`SRAM_ADDR_W-1:0] o_rd_addr,
    output logic                    o_wr_done
);

    sram_axi_if axi_bus ();
    sram_mem_if mem_bus ();

    sram_axi_master u_master (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_rw_type  (i_rw_type),
        .m_axi      (axi_bus.master),
        .o_rvalid   (o_rvalid),
        .o_rdata    (o_rdata),
        .o_rd_addr  (o_rd_addr),
        .o_wr_done  (o_wr_done)
    );

    sram_axi_slave u_slave (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .s_axi      (axi_bus.slave),
        .mem        (mem_bus.ctrl)
    );

    sram_mem u_mem (
        .i_aclk (i_aclk),
        .mem    (mem_bus.mem)
    );

endmodule

// File: design/sram_mem.sv
// ####################################################################
// Byte-strobed synchronous SRAM with registered read data
// Contents are undefined until written
// ####################################################################

`include "sram_axi_defines.svh"

module sram_mem (
    input  logic     i_aclk,
    sram_mem_if.mem  mem
);

    localparam int BYTE_W = `SRAM_DATA_W / `SRAM_STRB_W;

    logic [`SRAM_DATA_W-1:0] r_mem [`SRAM_DEPTH];
    logic [`SRAM_DATA_W-1:0] r_rdata;

    assign mem.rdata = r_rdata;

    always_ff @(posedge i_aclk) begin
        if (mem.en) begin
            if (mem.we) begin
                for (int i = 0; i < `SRAM_STRB_W; i++) begin
                    if (mem.wstrb[i]) begin
                        r_mem[mem.addr][i*BYTE_W +: BYTE_W] <= mem.wdata[i*BYTE_W +: BYTE_W];
                    end
                end
            end else begin
                r_rdata <= r_mem[mem.addr];    // Held until the next read access
            end
        end
    end

endmodule

// File: design/sram_mem_if.sv
// ####################################################################
// Plain strobed SRAM port, read data arrives one cycle after en
// ####################################################################

`include "sram_axi_defines.svh"

interface sram_mem_if;

    logic                    en;     // Access strobe, one cycle per access
    logic                    we;     // Write when high, read when low
    logic [`SRAM_ADDR_W-1:0] addr;
    logic [`SRAM_DATA_W-1:0] wdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
    logic [`SRAM_DATA_W-1:0] rdata;

    modport ctrl (
        output en, we, addr, wdata, wstrb,
        input  rdata
    );

    modport mem (
        input  en, we, addr, wdata, wstrb,
        output rdata
    );

endinterface

// File: sim.f
+incdir+design
design/sram_axi_pkg.sv
design/sram_axi_if.sv
design/sram_mem_if.sv
design/sram_axi_master.sv
design/sram_axi_slave.sv
design/sram_mem.sv
design/sram_axi_top.sv
test/sram_axi_tb.sv

// File: test/sram_axi_tb.sv
// ####################################################################
// Self-checking testbench, reads of unwritten addresses check only the address
// ####################################################################

`include "sram_axi_defines.svh"

module sram_axi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_WR     = 20;
    localparam int N_RD     = 20;
    localparam int N_TOGGLE = 4;      // Each round forces a write and a read
    localparam int N_RAND   = 100;
    localparam int TIMEOUT_CYCLES = (N_WR + N_RD + 2 * N_TOGGLE + N_RAND) * 10 + 200;

    logic                    i_aclk;
    logic                    i_areset_n;
    logic                    i_rw_type;
    logic                    o_rvalid;
    logic [`SRAM_DATA_W-1:0] o_rdata;
    logic [`SRAM_ADDR_W-1:0] o_rd_addr;
    logic                    o_wr_done;

    int    wr_count;
    int    rd_count;
    int    err_count;
    int    err_at_start;
    int    tests_passed;
    int    tests_failed;
    int    start_cnt;
    int    hold;
    string cur_test;

    sram_axi_top uut (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_rw_type  (i_rw_type),
        .o_rvalid   (o_rvalid),
        .o_rdata    (o_rdata),
        .o_rd_addr  (o_rd_addr),
        .o_wr_done  (o_wr_done)
    );

    always #5 i_aclk = ~i_aclk;

    task automatic note_fail(input string msg);
        err_count++;
        $display("Error in %s: %s", cur_test, msg);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        err_count++;
        $display("Mismatch in %s (%s): expected %0d, actual %0d", cur_test, what, exp, act);
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_count;
    endtask

    task automatic end_test;
        if (err_count == err_at_start) begin
            tests_passed++;
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail", cur_test);
        end
    endtask

    task automatic check_quiet;
        assert (!o_rvalid && !o_wr_done)
            else note_fail("o_rvalid or o_wr_done was high during or right after reset");
    endtask

    // Scoreboard samples the registered outputs of the cycle that just ended
    always @(posedge i_aclk) begin
        if (i_areset_n) begin
            if (o_wr_done) wr_count++;
            if (o_rvalid) begin
                rd_count++;
                assert (o_rd_addr == `SRAM_ADDR_W'(rd_count))
                    else report_mismatch("read address", rd_count, o_rd_addr);
                if (rd_count <= wr_count) begin    // Address a was written with 20 + a - 1
                    assert (o_rdata == `SRAM_DATA_W'(`SRAM_WDATA_INIT + rd_count - 1))
                        else report_mismatch("read data", `SRAM_WDATA_INIT + rd_count - 1, o_rdata);
                end
            end
            assert (!(o_rvalid && o_wr_done))
                else note_fail("o_rvalid and o_wr_done were high in the same cycle");
        end
    end

    no_wr_repeat: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        o_wr_done |=> !o_wr_done) else note_fail("o_wr_done pulsed on two consecutive cycles");
    no_rd_repeat: assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        o_rvalid |=> !o_rvalid) else note_fail("o_rvalid pulsed on two consecutive cycles");

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge i_aclk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h834e9f23));
        i_aclk     = 1'b0;
        i_areset_n = 1'b0;
        i_rw_type  = 1'b1;    // First traffic after reset is a write
        wr_count   = 0;
        rd_count   = 0;
        err_count  = 0;

        begin_test("reset");
        repeat (5) begin
            @(negedge i_aclk);
            check_quiet();
        end
        i_areset_n = 1'b1;
        repeat (2) begin
            @(negedge i_aclk);
            check_quiet();
        end
        end_test();

        begin_test("write_sequence");
        while (wr_count < N_WR) @(negedge i_aclk);
        end_test();

        begin_test("read_back");
        i_rw_type = 1'b0;
        while (rd_count < N_RD) @(negedge i_aclk);
        end_test();

        // A one-cycle glitch on the level while the other side is busy
        begin_test("mode_change");
        repeat (N_TOGGLE) begin
            start_cnt = wr_count;
            i_rw_type = 1'b1;
            repeat (2) @(negedge i_aclk);
            i_rw_type = 1'b0;
            @(negedge i_aclk);
            i_rw_type = 1'b1;
            while (wr_count <= start_cnt) @(negedge i_aclk);
            start_cnt = rd_count;
            i_rw_type = 1'b0;
            repeat (2) @(negedge i_aclk);
            i_rw_type = 1'b1;
            @(negedge i_aclk);
            i_rw_type = 1'b0;
            while (rd_count <= start_cnt) @(negedge i_aclk);
        end
        end_test();

        begin_test("random_mode");
        start_cnt = wr_count + rd_count;
        while (wr_count + rd_count < start_cnt + N_RAND) begin
            i_rw_type = 1'($urandom % 2);
            hold      = 1 + $urandom % 8;
            repeat (hold) @(negedge i_aclk);
        end
        repeat (10) @(negedge i_aclk);
        end_test();

        $display("Tests passed: %0d, tests failed: %0d, writes: %0d, reads: %0d",
                 tests_passed, tests_failed, wr_count, rd_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
